//--- controller.f
+incdir+verilog
verilog/controllerPkg.sv
verilog/mainDecoder.sv
verilog/aluDecoder.sv
verilog/controlPipeline.sv
verilog/controller.sv
testbench/controllerTb.sv

//--- Bender.yml
package:
  name: controller

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/controllerPkg.sv
      - verilog/mainDecoder.sv
      - verilog/aluDecoder.sv
      - verilog/controlPipeline.sv
      - verilog/controller.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/controllerTb.sv

//--- testbench/controllerTb.sv
//*************************************************
// Testbench for the pipeline control unit
// Stimulus table, expected-stage queue,
// compare tasks and watchdog
//*************************************************

`timescale 1ns/10ps

`include "controller_settings.svh"

module controllerTb;

    import controllerPkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ROWS     = 27;
    localparam int NUM_RANDOM   = 20;
    localparam int TOTAL_ROWS   = NUM_ROWS + NUM_RANDOM;
    localparam int WATCH_TIME   = (TOTAL_ROWS + 10) * CLK_PERIOD;

    // Single-bit controls of one decoded instruction
    typedef struct packed {
        logic regWrite;
        logic memWrite;
        logic aluSrc;
        logic branch;
        logic branchInvert;
        logic jump;
        logic jalr;
    } ctrlBitsT;

    typedef struct packed {
        logic [`CTRL_OP_WIDTH-1:0]     op;
        logic [`CTRL_FUNCT3_WIDTH-1:0] funct3;
        logic                          funct7b5;
        logic                          flushE;
        immSrcT                        immSrc;
        aluControlT                    aluControl;
        resultSrcT                     resultSrc;
        ctrlBitsT                      bits;
    } rowT;

    localparam rowT BUBBLE = '{7'd0, 3'd0, 1'b0, 1'b0, IMM_I, ADD, RES_ALU, 7'b0000000};

    logic                          clk;
    logic                          rstN;
    logic [`CTRL_OP_WIDTH-1:0]     op;
    logic [`CTRL_FUNCT3_WIDTH-1:0] funct3;
    logic                          funct7b5;
    logic                          zeroE;
    logic                          flushE;
    resultSrcT                     resultSrcW;
    logic                          memWriteM;
    logic                          pcSrcE;
    logic                          pcJalSrcE;
    logic                          aluSrcE;
    logic                          regWriteW;
    logic                          regWriteM;
    immSrcT                        immSrcD;
    aluControlT                    aluControlE;

    rowT         rowTable [NUM_ROWS];
    rowT         pending [$]; // Oldest entry is in writeback
    logic [31:0] rngState;

    controller u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .op          (op),
        .funct3      (funct3),
        .funct7b5    (funct7b5),
        .zeroE       (zeroE),
        .flushE      (flushE),
        .resultSrcW  (resultSrcW),
        .memWriteM   (memWriteM),
        .pcSrcE      (pcSrcE),
        .pcJalSrcE   (pcJalSrcE),
        .aluSrcE     (aluSrcE),
        .regWriteW   (regWriteW),
        .regWriteM   (regWriteM),
        .immSrcD     (immSrcD),
        .aluControlE (aluControlE)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCH_TIME);
        $display("Timeout: the run did not finish within %0d ns", WATCH_TIME);
        stopOnFailure();
    end

    task automatic stopOnFailure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkResultSrc(input string name, input resultSrcT expVal,
                                  input resultSrcT actVal);
        if (actVal !== expVal) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkImmSrc(input string name, input immSrcT expVal, input immSrcT actVal);
        if (actVal !== expVal) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkAluControl(input string name, input aluControlT expVal,
                                   input aluControlT actVal);
        if (actVal !== expVal) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
            stopOnFailure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bits are regWrite memWrite aluSrc branch branchInvert jump jalr
    task automatic loadRowTable();
        rowTable[0]  = '{LOAD,    3'b010, 1'b0, 1'b0, IMM_I, ADD, RES_MEM, 7'b1010000};
        rowTable[1]  = '{STORE,   3'b010, 1'b0, 1'b0, IMM_S, ADD, RES_ALU, 7'b0110000};
        rowTable[2]  = '{RTYPE,   3'b000, 1'b0, 1'b0, IMM_I, ADD, RES_ALU, 7'b1000000};
        rowTable[3]  = '{RTYPE,   3'b000, 1'b1, 1'b0, IMM_I, SUB, RES_ALU, 7'b1000000};
        rowTable[4]  = '{RTYPE,   3'b001, 1'b0, 1'b0, IMM_I, SLL, RES_ALU, 7'b1000000};
        rowTable[5]  = '{RTYPE,   3'b010, 1'b0, 1'b0, IMM_I, SLT, RES_ALU, 7'b1000000};
        rowTable[6]  = '{RTYPE,   3'b011, 1'b0, 1'b0, IMM_I, SLT, RES_ALU, 7'b1000000};
        rowTable[7]  = '{RTYPE,   3'b100, 1'b0, 1'b0, IMM_I, XOR, RES_ALU, 7'b1000000};
        rowTable[8]  = '{RTYPE,   3'b101, 1'b0, 1'b0, IMM_I, SRL, RES_ALU, 7'b1000000};
        rowTable[9]  = '{RTYPE,   3'b101, 1'b1, 1'b0, IMM_I, SRL, RES_ALU, 7'b1000000};
        rowTable[10] = '{RTYPE,   3'b110, 1'b0, 1'b0, IMM_I, OR,  RES_ALU, 7'b1000000};
        rowTable[11] = '{RTYPE,   3'b111, 1'b0, 1'b0, IMM_I, AND, RES_ALU, 7'b1000000};
        // I-type ignores funct7 bit 5 for add
        rowTable[12] = '{ITYPE,   3'b000, 1'b1, 1'b0, IMM_I, ADD, RES_ALU, 7'b1010000};
        rowTable[13] = '{ITYPE,   3'b001, 1'b0, 1'b0, IMM_I, SLL, RES_ALU, 7'b1010000};
        rowTable[14] = '{ITYPE,   3'b010, 1'b0, 1'b0, IMM_I, SLT, RES_ALU, 7'b1010000};
        rowTable[15] = '{ITYPE,   3'b100, 1'b0, 1'b0, IMM_I, XOR, RES_ALU, 7'b1010000};
        rowTable[16] = '{ITYPE,   3'b101, 1'b1, 1'b0, IMM_I, SRL, RES_ALU, 7'b1010000};
        rowTable[17] = '{ITYPE,   3'b110, 1'b0, 1'b0, IMM_I, OR,  RES_ALU, 7'b1010000};
        rowTable[18] = '{ITYPE,   3'b111, 1'b0, 1'b0, IMM_I, AND, RES_ALU, 7'b1010000};
        rowTable[19] = '{BRANCH,  3'b000, 1'b0, 1'b0, IMM_B, SUB, RES_ALU, 7'b0001000}; // BEQ
        rowTable[20] = '{BRANCH,  3'b001, 1'b0, 1'b0, IMM_B, SUB, RES_ALU, 7'b0001100}; // BNE
        rowTable[21] = '{JAL,     3'b000, 1'b0, 1'b0, IMM_J, ADD, RES_PC4, 7'b1000010};
        rowTable[22] = '{JALR,    3'b000, 1'b0, 1'b0, IMM_I, ADD, RES_PC4, 7'b1010011};
        rowTable[23] = '{LUI,     3'b000, 1'b0, 1'b0, IMM_U, ADD, RES_ALU, 7'b1010000};
        rowTable[24] = '{7'h7f,   3'b000, 1'b0, 1'b0, IMM_I, ADD, RES_ALU, 7'b0000000};
        // Flushed rows enter execute as bubbles
        rowTable[25] = '{JAL,     3'b000, 1'b0, 1'b1, IMM_J, ADD, RES_PC4, 7'b1000010};
        rowTable[26] = '{LOAD,    3'b010, 1'b0, 1'b1, IMM_I, ADD, RES_MEM, 7'b1010000};
    endtask

    task automatic checkResetState();
        checkBit("aluSrcE", 1'b0, aluSrcE);
        checkAluControl("aluControlE", ADD, aluControlE);
        checkBit("pcJalSrcE", 1'b0, pcJalSrcE);
        checkBit("memWriteM", 1'b0, memWriteM);
        checkBit("regWriteM", 1'b0, regWriteM);
        checkBit("regWriteW", 1'b0, regWriteW);
        checkResultSrc("resultSrcW", RES_ALU, resultSrcW);
        checkBit("pcSrcE", 1'b0, pcSrcE);
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic applyRow(input rowT row);
        rowT  exRow;
        rowT  memRow;
        rowT  wbRow;
        logic taken;
        op       = row.op;
        funct3   = row.funct3;
        funct7b5 = row.funct7b5;
        flushE   = row.flushE;
        rngState = xorshift32(rngState);
        zeroE    = rngState[0];
        @(negedge clk);
        exRow  = pending[2];
        memRow = pending[1];
        wbRow  = pending[0];
        checkImmSrc("immSrcD", row.immSrc, immSrcD);
        checkBit("aluSrcE", exRow.bits.aluSrc, aluSrcE);
        checkAluControl("aluControlE", exRow.aluControl, aluControlE);
        // BEQ is taken on zero, BNE on nonzero, jumps always
        taken = exRow.bits.jump;
        if (exRow.bits.branch) begin
            taken = exRow.bits.branchInvert ? !zeroE : zeroE;
        end
        checkBit("pcSrcE", taken, pcSrcE);
        checkBit("pcJalSrcE", exRow.bits.jalr, pcJalSrcE);
        checkBit("memWriteM", memRow.bits.memWrite, memWriteM);
        checkBit("regWriteM", memRow.bits.regWrite, regWriteM);
        checkBit("regWriteW", wbRow.bits.regWrite, regWriteW);
        checkResultSrc("resultSrcW", wbRow.resultSrc, resultSrcW);
        pending.push_back(row.flushE ? BUBBLE : row);
        pending.delete(0);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int pick;
        loadRowTable();
        rngState = 32'd3;
        rstN     = 1'b0;
        op       = JAL;    // Active decode while the registers are held in reset
        funct3   = 3'b000;
        funct7b5 = 1'b0;
        zeroE    = 1'b0;
        flushE   = 1'b0;
        for (int i = 0; i < 3; i++) begin
            pending.push_back(BUBBLE);
        end
        repeat (RESET_CYCLES - 2) @(posedge clk);
        // Both zeroE values while the registers are still in reset
        for (int i = 0; i < 2; i++) begin
            #1;
            zeroE = i[0];
            @(negedge clk);
            checkResetState();
            @(posedge clk);
        end
        #1;
        rstN = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            applyRow(rowTable[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rngState = xorshift32(rngState);
            pick     = rngState % NUM_ROWS;
            applyRow(rowTable[pick]);
        end
        // Drain the last rows through writeback
        repeat (3) applyRow(BUBBLE);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog/controller.sv
//*************************************************
// Five-stage pipeline control unit, top level
// Main and ALU decoders feeding the
// stage control registers
//*************************************************

`timescale 1ns/10ps

`include "controller_settings.svh"

module controller (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [`CTRL_OP_WIDTH-1:0]     op,
    input  logic [`CTRL_FUNCT3_WIDTH-1:0] funct3,
    input  logic                          funct7b5,
    input  logic                          zeroE,
    input  logic                          flushE,
    output controllerPkg::resultSrcT      resultSrcW,
    output logic                          memWriteM,
    output logic                          pcSrcE,
    output logic                          pcJalSrcE,
    output logic                          aluSrcE,
    output logic                          regWriteW,
    output logic                          regWriteM,
    output controllerPkg::immSrcT         immSrcD,
    output controllerPkg::aluControlT     aluControlE
);

    import controllerPkg::*;

    mainCtrlT   mainCtrlD;
    aluOpT      aluOpD;
    aluControlT aluControlD;
    execCtrlT   ctrlD;
    execCtrlT   ctrlE;
    memCtrlT    ctrlM;
    wbCtrlT     ctrlW;

    mainDecoder u_mainDec (
        .op     (opcodeT'(op)), // Illegal codes decode as bubble
        .funct3 (funct3),
        .ctrl   (mainCtrlD),
        .aluOp  (aluOpD),
        .immSrc (immSrcD)
    );

    aluDecoder u_aluDec (
        .aluOp      (aluOpD),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .opb5       (op[5]),
        .aluControl (aluControlD)
    );

    // Decode-stage bundle for the execute register
    assign ctrlD.main       = mainCtrlD;
    assign ctrlD.aluControl = aluControlD;

    controlPipeline u_pipe (
        .clk       (clk),
        .rstN      (rstN),
        .flushE    (flushE),
        .ctrlD     (ctrlD),
        .zeroE     (zeroE),
        .ctrlE     (ctrlE),
        .pcSrcE    (pcSrcE),
        .pcJalSrcE (pcJalSrcE),
        .ctrlM     (ctrlM),
        .ctrlW     (ctrlW)
    );

    assign aluSrcE     = ctrlE.main.aluSrc;
    assign aluControlE = ctrlE.aluControl;
    assign memWriteM   = ctrlM.memWrite;
    assign regWriteM   = ctrlM.regWrite;
    assign regWriteW   = ctrlW.regWrite;
    assign resultSrcW  = ctrlW.resultSrc;

endmodule

//--- verilog/controlPipeline.sv
//*************************************************
// Control pipeline registers
// Decode-to-execute register with flush,
// memory and writeback registers, and
// branch resolution in execute
//*************************************************

`timescale 1ns/10ps

module controlPipeline (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   flushE,
    input  controllerPkg::execCtrlT ctrlD,
    input  logic                   zeroE,
    output controllerPkg::execCtrlT ctrlE,
    output logic                   pcSrcE,
    output logic                   pcJalSrcE,
    output controllerPkg::memCtrlT  ctrlM,
    output controllerPkg::wbCtrlT   ctrlW
);

    logic zeroSense;

    // Decode to execute
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlE <= '0;
        end else if (flushE) begin
            ctrlE <= '0; // Bubble
        end else begin
            ctrlE <= ctrlD;
        end
    end

    // Execute to memory, only the fields still needed downstream
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlM <= '0;
        end else begin
            ctrlM.regWrite  <= ctrlE.main.regWrite;
            ctrlM.memWrite  <= ctrlE.main.memWrite;
            ctrlM.resultSrc <= ctrlE.main.resultSrc;
        end
    end

    // Memory to writeback
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlW <= '0;
        end else begin
            ctrlW.regWrite  <= ctrlM.regWrite;
            ctrlW.resultSrc <= ctrlM.resultSrc;
        end
    end

    // BEQ wants zero set, BNE wants it clear
    assign zeroSense = zeroE ^ ctrlE.main.branchInvert;

    assign pcSrcE    = (ctrlE.main.branch & zeroSense) | ctrlE.main.jump;
    assign pcJalSrcE = ctrlE.main.jalr; // Select ALU result as target

endmodule

//--- verilog/aluDecoder.sv
//*************************************************
// ALU operation decoder
// Maps ALU-op class and function fields to
// the ALU control code
//*************************************************

`timescale 1ns/10ps

`include "controller_settings.svh"

module aluDecoder (
    input  controllerPkg::aluOpT             aluOp,
    input  logic [`CTRL_FUNCT3_WIDTH-1:0]    funct3,
    input  logic                             funct7b5,
    input  logic                             opb5,
    output controllerPkg::aluControlT        aluControl
);

    import controllerPkg::*;

    always_comb begin
        aluControl = ADD;

        case (aluOp)
            ADDOP:    aluControl = ADD;
            BRANCHOP: aluControl = SUB;
            PASSB:    aluControl = ADD; // Operand A is zeroed in the datapath
            FUNCOP: begin
                case (funct3)
                    3'b000: begin
                        // Only R-type carries a subtract in funct7
                        if (opb5 && funct7b5) begin
                            aluControl = SUB;
                        end else begin
                            aluControl = ADD;
                        end
                    end
                    3'b001:  aluControl = SLL;
                    3'b010:  aluControl = SLT;
                    3'b011:  aluControl = SLT; // SLTU shares the comparator
                    3'b100:  aluControl = XOR;
                    3'b101:  aluControl = SRL;
                    3'b110:  aluControl = OR;
                    3'b111:  aluControl = AND;
                    default: aluControl = ADD;
                endcase
            end
            default: aluControl = ADD;
        endcase
    end

endmodule

//--- verilog/mainDecoder.sv
//*************************************************
// Main opcode decoder
// Main control fields, ALU-op class and
// immediate select for the decode stage
//*************************************************

`timescale 1ns/10ps

`include "controller_settings.svh"

module mainDecoder (
    input  controllerPkg::opcodeT            op,
    input  logic [`CTRL_FUNCT3_WIDTH-1:0]    funct3,
    output controllerPkg::mainCtrlT          ctrl,
    output controllerPkg::aluOpT             aluOp,
    output controllerPkg::immSrcT            immSrc
);

    import controllerPkg::*;

    always_comb begin
        // Unknown opcodes fall through as a bubble
        ctrl   = '0;
        aluOp  = ADDOP;
        immSrc = IMM_I;

        case (op)
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_MEM;
            end
            STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immSrc        = IMM_S;
            end
            RTYPE: begin
                ctrl.regWrite = 1'b1;
                aluOp         = FUNCOP;
            end
            ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                aluOp         = FUNCOP;
            end
            BRANCH: begin
                ctrl.branch       = 1'b1;
                ctrl.branchInvert = funct3[0]; // BNE inverts the zero test
                immSrc            = IMM_B;
                aluOp             = BRANCHOP;
            end
            JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = RES_PC4; // Link address
                immSrc         = IMM_J;
            end
            JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;    // Target comes from the ALU
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_PC4;
            end
            LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immSrc        = IMM_U;
                aluOp         = PASSB;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

//--- verilog/controllerPkg.sv
//*************************************************
// Types for the RV32I pipeline controller
// Opcode, ALU and mux-select encodings
// Per-stage control structs
//*************************************************

`include "controller_settings.svh"

package controllerPkg;

    // Base opcodes handled by the core
    typedef enum logic [`CTRL_OP_WIDTH-1:0] {
        LOAD   = 7'b0000011,
        ITYPE  = 7'b0010011,
        STORE  = 7'b0100011,
        RTYPE  = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcodeT;

    // Class of ALU work, refined by the ALU decoder
    typedef enum logic [1:0] {
        ADDOP    = 2'b00, // Address arithmetic
        BRANCHOP = 2'b01, // Compare by subtraction
        FUNCOP   = 2'b10, // Taken from funct3
        PASSB    = 2'b11  // LUI
    } aluOpT;

    typedef enum logic [2:0] {
        ADD = 3'b000,
        SUB = 3'b001,
        AND = 3'b010,
        OR  = 3'b011,
        XOR = 3'b100,
        SLT = 3'b101,
        SLL = 3'b110,
        SRL = 3'b111
    } aluControlT;

    // Writeback mux select
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } resultSrcT;

    // Immediate format select for decode
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrcT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      jump;
        logic      branch;
        logic      branchInvert; // BNE sense
        logic      jalr;
        logic      aluSrc;       // Immediate as operand B
        resultSrcT resultSrc;
    } mainCtrlT;

    // Execute stage payload
    typedef struct packed {
        mainCtrlT   main;
        aluControlT aluControl;
    } execCtrlT;

    // Memory stage payload
    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        resultSrcT resultSrc;
    } memCtrlT;

    // Writeback stage payload
    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
    } wbCtrlT;

endpackage

//--- verilog/controller_settings.svh
//*************************************************
// Width settings for the RV32I pipeline controller
// Opcode and funct3 field widths
//*************************************************

`ifndef CONTROLLER_SETTINGS_SVH
`define CONTROLLER_SETTINGS_SVH

// Instruction bits [6:0]
`define CTRL_OP_WIDTH 7

// Instruction bits [14:12]
`define CTRL_FUNCT3_WIDTH 3

`endif
